// File: include/armv4t_cfg.svh
`ifndef ARMV4T_CFG_SVH
`define ARMV4T_CFG_SVH

// architectural sizes
`define ARM_XLEN      32
`define ARM_NREGS     16
`define ARM_RESET_PC  32'h0000_0000
`define ARM_PC_IDX    15
`define ARM_LR_IDX    14

// instruction field positions
`define ARM_COND_HI   31
`define ARM_COND_LO   28
`define ARM_OPC_HI    24
`define ARM_OPC_LO    21
`define ARM_S_BIT     20
`define ARM_RN_HI     19
`define ARM_RN_LO     16
`define ARM_RD_HI     15
`define ARM_RD_LO     12

`endif

// File: source/armv4t_pkg.sv
package armv4t_pkg;

	typedef enum logic [2:0] {
		CS_RESET,
		CS_FETCH,
		CS_DECODE,
		CS_EXEC,
		CS_MEM
	} cpu_state_e;

	// data processing opcodes, encoding order of bits 24..21
	typedef enum logic [3:0] {
		OP_AND, OP_EOR, OP_SUB, OP_RSB,
		OP_ADD, OP_ADC, OP_SBC, OP_RSC,
		OP_TST, OP_TEQ, OP_CMP, OP_CMN,
		OP_ORR, OP_MOV, OP_BIC, OP_MVN
	} dp_opcode_e;

	typedef enum logic [3:0] {
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL, COND_NV
	} cond_e;

	typedef enum logic [1:0] {
		SH_LSL,
		SH_LSR,
		SH_ASR,
		SH_ROR
	} shift_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} arm_flags_t;

	typedef logic [3:0] reg_idx_t;

endpackage

// File: source/arm_exec_if.sv
`include "armv4t_cfg.svh"

// operand and result bundle of the execute datapath
interface arm_exec_if
	import armv4t_pkg::*;
();
	dp_opcode_e            opcode;
	logic [`ARM_XLEN-1:0]  op_a;
	logic [`ARM_XLEN-1:0]  op_b;
	logic                  shift_carry;
	arm_flags_t            flags_in;
	logic [`ARM_XLEN-1:0]  result;
	arm_flags_t            flags_out;
	logic                  writes_rd;

	modport regfile (output op_a);
	modport shifter (output op_b, output shift_carry);
	modport alu (
		input  opcode, op_a, op_b, shift_carry, flags_in,
		output result, flags_out, writes_rd
	);
	modport ctrl (
		output opcode, flags_in,
		input  result, flags_out, writes_rd
	);
endinterface

// File: source/arm_regfile.sv
`include "armv4t_cfg.svh"

module arm_regfile
	import armv4t_pkg::*;
(
	input  logic                 clk,
	input  logic                 rstn,
	input  reg_idx_t             i_rn_idx,
	input  reg_idx_t             i_rm_idx,
	input  reg_idx_t             i_rs_idx,
	input  logic                 i_we,
	input  reg_idx_t             i_wr_idx,
	input  logic [`ARM_XLEN-1:0] i_wr_data,
	input  logic [`ARM_XLEN-1:0] i_pc,
	output logic [`ARM_XLEN-1:0] o_rm_val,
	output logic [`ARM_XLEN-1:0] o_rs_val,
	arm_exec_if.regfile          ex
);
	logic [`ARM_XLEN-1:0] regs [0:`ARM_NREGS-2]; // r0..r14, pc is in ctrl

	// r15 reads as the instruction address plus 8
	function automatic logic [`ARM_XLEN-1:0] read_port(reg_idx_t idx);
		if (idx == reg_idx_t'(`ARM_PC_IDX))
			return i_pc + `ARM_XLEN'd8;
		return regs[idx];
	endfunction

	assign ex.op_a  = read_port(i_rn_idx);
	assign o_rm_val = read_port(i_rm_idx);
	assign o_rs_val = read_port(i_rs_idx); // also store data

	always_ff @(posedge clk) begin
		if (rstn && i_we && i_wr_idx != reg_idx_t'(`ARM_PC_IDX))
			regs[i_wr_idx] <= i_wr_data;
	end
endmodule

// File: source/arm_barrel_shifter.sv
`include "armv4t_cfg.svh"

module arm_barrel_shifter
	import armv4t_pkg::*;
(
	input  logic [`ARM_XLEN-1:0] i_instr,
	input  logic [`ARM_XLEN-1:0] i_rm_val,
	input  logic [`ARM_XLEN-1:0] i_rs_val,
	input  logic                 i_c_flag,
	arm_exec_if.shifter          ex
);
	shift_e             kind;
	logic [7:0]         amt;
	logic               rrx;
	logic [63:0]        imm_rot;
	logic [32:0]        lsl_ext;
	logic [32:0]        lsr_ext;
	logic signed [32:0] asr_ext;
	logic [63:0]        ror_dbl;
	logic [31:0]        sh_val;
	logic               sh_c;

	assign kind    = shift_e'(i_instr[6:5]);
	assign imm_rot = {{24'b0, i_instr[7:0]}, {24'b0, i_instr[7:0]}} >> {i_instr[11:8], 1'b0};

	// shift amount, immediate encodings of zero remapped
	always_comb begin
		rrx = 1'b0;
		if (i_instr[4]) begin
			amt = i_rs_val[7:0]; // by register, bottom byte
		end else begin
			amt = {3'b000, i_instr[11:7]};
			if (amt == 8'd0) begin
				case (kind)
					SH_LSR, SH_ASR: amt = 8'd32;
					SH_ROR:         rrx = 1'b1;
					default:        ;
				endcase
			end
		end
	end

	// extra bit on each side catches the last bit shifted out
	assign lsl_ext = {1'b0, i_rm_val} << amt;
	assign lsr_ext = {i_rm_val, 1'b0} >> amt;
	assign asr_ext = $signed({i_rm_val, 1'b0}) >>> amt;
	assign ror_dbl = {i_rm_val, i_rm_val} >> amt[4:0];

	always_comb begin
		if (rrx) begin
			sh_val = {i_c_flag, i_rm_val[31:1]};
			sh_c   = i_rm_val[0];
		end else if (amt == 8'd0) begin
			sh_val = i_rm_val;
			sh_c   = i_c_flag;
		end else begin
			case (kind)
				SH_LSL:  {sh_c, sh_val} = lsl_ext;
				SH_LSR:  {sh_val, sh_c} = lsr_ext;
				SH_ASR:  {sh_val, sh_c} = asr_ext;
				default: begin
					sh_val = ror_dbl[31:0];
					sh_c   = ror_dbl[31];
				end
			endcase
		end
	end

	always_comb begin
		if (i_instr[27:26] == 2'b01) begin // load/store offset
			ex.op_b        = {20'b0, i_instr[11:0]};
			ex.shift_carry = i_c_flag;
		end else if (i_instr[25]) begin
			ex.op_b        = imm_rot[31:0];
			ex.shift_carry = (i_instr[11:8] == 4'd0) ? i_c_flag : imm_rot[31];
		end else begin
			ex.op_b        = sh_val;
			ex.shift_carry = sh_c;
		end
	end
endmodule

// File: source/arm_alu.sv
`include "armv4t_cfg.svh"

module arm_alu
	import armv4t_pkg::*;
(
	arm_exec_if.alu ex
);
	logic [`ARM_XLEN-1:0] add_x;
	logic [`ARM_XLEN-1:0] add_y;
	logic                 add_ci;
	logic                 arith;
	logic [`ARM_XLEN:0]   sum;
	logic [`ARM_XLEN-1:0] res;

	// adder operands, subtraction as x + ~y + 1
	always_comb begin
		add_x  = ex.op_a;
		add_y  = ex.op_b;
		add_ci = 1'b0;
		arith  = 1'b1;
		case (ex.opcode)
			OP_SUB, OP_CMP: begin
				add_y  = ~ex.op_b;
				add_ci = 1'b1;
			end
			OP_RSB: begin
				add_x  = ex.op_b;
				add_y  = ~ex.op_a;
				add_ci = 1'b1;
			end
			OP_ADD, OP_CMN: ;
			OP_ADC: add_ci = ex.flags_in.c;
			OP_SBC: begin
				add_y  = ~ex.op_b;
				add_ci = ex.flags_in.c;
			end
			OP_RSC: begin
				add_x  = ex.op_b;
				add_y  = ~ex.op_a;
				add_ci = ex.flags_in.c;
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, add_x} + {1'b0, add_y} + {{`ARM_XLEN{1'b0}}, add_ci};

	always_comb begin
		case (ex.opcode)
			OP_AND, OP_TST: res = ex.op_a & ex.op_b;
			OP_EOR, OP_TEQ: res = ex.op_a ^ ex.op_b;
			OP_ORR:         res = ex.op_a | ex.op_b;
			OP_MOV:         res = ex.op_b;
			OP_BIC:         res = ex.op_a & ~ex.op_b;
			OP_MVN:         res = ~ex.op_b;
			default:        res = sum[`ARM_XLEN-1:0];
		endcase
	end

	always_comb begin
		ex.flags_out.n = res[`ARM_XLEN-1];
		ex.flags_out.z = (res == '0);
		ex.flags_out.c = arith ? sum[`ARM_XLEN] : ex.shift_carry;
		ex.flags_out.v = ex.flags_in.v; // logical ops keep V
		if (arith)
			ex.flags_out.v = (add_x[31] == add_y[31]) && (res[31] != add_x[31]);
	end

	assign ex.result    = res;
	assign ex.writes_rd = !(ex.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});
endmodule

// File: source/arm_core_ctrl.sv
`include "armv4t_cfg.svh"

module arm_core_ctrl
	import armv4t_pkg::*;
(
	input  logic                 clk,
	input  logic                 rstn,
	arm_exec_if.ctrl             ex,
	output reg_idx_t             o_rn_idx,
	output reg_idx_t             o_rm_idx,
	output reg_idx_t             o_rs_idx,
	output logic                 o_rf_we,
	output reg_idx_t             o_rf_wr_idx,
	output logic [`ARM_XLEN-1:0] o_rf_wr_data,
	output logic [`ARM_XLEN-1:0] o_pc,
	output logic [`ARM_XLEN-1:0] o_instr,
	input  logic [`ARM_XLEN-1:0] i_rs_val,
	output logic [`ARM_XLEN-1:0] o_wb_adr,
	output logic [`ARM_XLEN-1:0] o_wb_dat,
	input  logic [`ARM_XLEN-1:0] i_wb_dat,
	output logic                 o_wb_we,
	output logic [3:0]           o_wb_sel,
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	input  logic                 i_wb_ack
);
	cpu_state_e           state_q;
	cpu_state_e           state_d;
	logic [`ARM_XLEN-1:0] pc_q;
	logic [`ARM_XLEN-1:0] pc_d;
	arm_flags_t           flags_q;
	arm_flags_t           flags_d;
	logic                 pass_q;
	logic                 wr_q;
	logic                 ack_q;    // bus idle in the cycle after an ack
	arm_flags_t           res_flags_q;
	logic [`ARM_XLEN-1:0] instr_q;
	logic [`ARM_XLEN-1:0] res_q;    // dp result or memory address
	logic [`ARM_XLEN-1:0] st_dat_q;
	reg_idx_t             rd;
	logic                 is_dp;
	logic                 is_br;
	logic                 is_ls;
	logic                 is_byte;
	logic                 is_load;
	logic [`ARM_XLEN-1:0] pc_seq;
	logic [`ARM_XLEN-1:0] br_target;
	logic [`ARM_XLEN-1:0] ld_shift;
	logic [`ARM_XLEN-1:0] ld_data;

	function automatic logic cond_ok(cond_e c, arm_flags_t f);
		case (c)
			COND_EQ: return f.z;
			COND_NE: return !f.z;
			COND_CS: return f.c;
			COND_CC: return !f.c;
			COND_MI: return f.n;
			COND_PL: return !f.n;
			COND_VS: return f.v;
			COND_VC: return !f.v;
			COND_HI: return f.c && !f.z;
			COND_LS: return !f.c || f.z;
			COND_GE: return f.n == f.v;
			COND_LT: return f.n != f.v;
			COND_GT: return !f.z && (f.n == f.v);
			COND_LE: return f.z || (f.n != f.v);
			COND_AL: return 1'b1;
			default: return 1'b0; // NV never runs
		endcase
	endfunction

	// instruction classes, anything else is a no-op
	assign is_dp = (instr_q[27:26] == 2'b00) && !(!instr_q[25] && instr_q[7] && instr_q[4])
		&& !(instr_q[24:23] == 2'b10 && !instr_q[`ARM_S_BIT]);
	assign is_br   = (instr_q[27:25] == 3'b101);
	assign is_ls   = (instr_q[27:26] == 2'b01) && !instr_q[25] && instr_q[24] && !instr_q[21];
	assign is_byte = instr_q[22];
	assign is_load = instr_q[20];
	assign rd      = instr_q[`ARM_RD_HI:`ARM_RD_LO];

	assign o_rn_idx = instr_q[`ARM_RN_HI:`ARM_RN_LO];
	assign o_rm_idx = instr_q[3:0];
	assign o_rs_idx = is_ls ? rd : instr_q[11:8]; // store data or shift amount
	assign o_pc     = pc_q;
	assign o_instr  = instr_q;

	assign ex.opcode   = is_ls ? (instr_q[23] ? OP_ADD : OP_SUB)
		: dp_opcode_e'(instr_q[`ARM_OPC_HI:`ARM_OPC_LO]);
	assign ex.flags_in = flags_q;

	assign pc_seq    = pc_q + `ARM_XLEN'd4;
	assign br_target = pc_q + `ARM_XLEN'd8 + {{6{instr_q[23]}}, instr_q[23:0], 2'b00};
	assign ld_shift  = i_wb_dat >> {res_q[1:0], 3'b000};
	assign ld_data   = is_byte ? {24'b0, ld_shift[7:0]} : i_wb_dat;

	always_comb begin
		state_d      = state_q;
		pc_d         = pc_q;
		flags_d      = flags_q;
		o_rf_we      = 1'b0;
		o_rf_wr_idx  = rd;
		o_rf_wr_data = res_q;
		case (state_q)
			CS_RESET: begin
				state_d = CS_FETCH;
				pc_d    = `ARM_RESET_PC;
			end
			CS_FETCH: if (i_wb_ack) state_d = CS_DECODE;
			CS_DECODE: state_d = CS_EXEC;
			CS_EXEC: begin
				state_d = CS_FETCH;
				pc_d    = pc_seq;
				if (pass_q && is_dp) begin
					if (instr_q[`ARM_S_BIT])
						flags_d = res_flags_q;
					if (wr_q && rd == reg_idx_t'(`ARM_PC_IDX))
						pc_d = res_q;
					else
						o_rf_we = wr_q;
				end else if (pass_q && is_br) begin
					pc_d         = br_target;
					o_rf_we      = instr_q[24]; // BL
					o_rf_wr_idx  = reg_idx_t'(`ARM_LR_IDX);
					o_rf_wr_data = pc_seq;
				end else if (pass_q && is_ls) begin
					state_d = CS_MEM;
					pc_d    = pc_q;
				end
			end
			CS_MEM: begin
				if (i_wb_ack) begin
					state_d      = CS_FETCH;
					pc_d         = pc_seq;
					o_rf_wr_data = ld_data;
					if (is_load && rd == reg_idx_t'(`ARM_PC_IDX))
						pc_d = ld_data;
					else
						o_rf_we = is_load;
				end
			end
			default: state_d = CS_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q     <= CS_RESET;
			pc_q        <= `ARM_RESET_PC;
			flags_q     <= '0;
			pass_q      <= 1'b0;
			wr_q        <= 1'b0;
			ack_q       <= 1'b0;
			res_flags_q <= '0;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
			flags_q <= flags_d;
			ack_q   <= o_wb_cyc && i_wb_ack;
			if (state_q == CS_DECODE) begin
				pass_q      <= cond_ok(cond_e'(instr_q[`ARM_COND_HI:`ARM_COND_LO]), flags_q);
				wr_q        <= ex.writes_rd;
				res_flags_q <= ex.flags_out;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == CS_FETCH && i_wb_ack)
			instr_q <= i_wb_dat;
		if (state_q == CS_DECODE) begin
			res_q    <= ex.result;
			st_dat_q <= is_byte ? {4{i_rs_val[7:0]}} : i_rs_val; // byte on every lane
		end
	end

	assign o_wb_cyc = ((state_q == CS_FETCH) || (state_q == CS_MEM)) && !ack_q;
	assign o_wb_stb = o_wb_cyc;
	assign o_wb_adr = (state_q == CS_MEM) ? res_q : pc_q;
	assign o_wb_we  = (state_q == CS_MEM) && !is_load;
	assign o_wb_sel = (state_q == CS_MEM && is_byte) ? (4'b0001 << res_q[1:0]) : 4'hf;
	assign o_wb_dat = st_dat_q;
endmodule

// File: source/armv4t_lite.sv
`include "armv4t_cfg.svh"

module armv4t_lite
	import armv4t_pkg::*;
(
	input  logic                 clk,
	input  logic                 rstn,
	output logic [`ARM_XLEN-1:0] o_wb_adr,
	output logic [`ARM_XLEN-1:0] o_wb_dat,
	input  logic [`ARM_XLEN-1:0] i_wb_dat,
	output logic                 o_wb_we,
	output logic [3:0]           o_wb_sel,
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	input  logic                 i_wb_ack
);
	reg_idx_t             rn_idx;
	reg_idx_t             rm_idx;
	reg_idx_t             rs_idx;
	logic                 rf_we;
	reg_idx_t             rf_wr_idx;
	logic [`ARM_XLEN-1:0] rf_wr_data;
	logic [`ARM_XLEN-1:0] pc;
	logic [`ARM_XLEN-1:0] instr;
	logic [`ARM_XLEN-1:0] rm_val;
	logic [`ARM_XLEN-1:0] rs_val;

	arm_exec_if ex ();

	arm_regfile u_regfile (
		.clk(clk), .rstn(rstn),
		.i_rn_idx(rn_idx), .i_rm_idx(rm_idx), .i_rs_idx(rs_idx),
		.i_we(rf_we), .i_wr_idx(rf_wr_idx), .i_wr_data(rf_wr_data),
		.i_pc(pc), .o_rm_val(rm_val), .o_rs_val(rs_val), .ex(ex)
	);

	arm_barrel_shifter u_shifter (
		.i_instr(instr), .i_rm_val(rm_val), .i_rs_val(rs_val),
		.i_c_flag(ex.flags_in.c), .ex(ex)
	);

	arm_alu u_alu (.ex(ex));

	arm_core_ctrl u_ctrl (
		.clk(clk), .rstn(rstn), .ex(ex),
		.o_rn_idx(rn_idx), .o_rm_idx(rm_idx), .o_rs_idx(rs_idx),
		.o_rf_we(rf_we), .o_rf_wr_idx(rf_wr_idx), .o_rf_wr_data(rf_wr_data),
		.o_pc(pc), .o_instr(instr), .i_rs_val(rs_val),
		.o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .i_wb_dat(i_wb_dat),
		.o_wb_we(o_wb_we), .o_wb_sel(o_wb_sel), .o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb), .i_wb_ack(i_wb_ack)
	);
endmodule

// File: verif/armv4t_lite_assert.sv
`include "armv4t_cfg.svh"

module armv4t_lite_assert (
	input logic                 clk,
	input logic                 rstn,
	input logic                 i_wb_cyc,
	input logic                 i_wb_stb,
	input logic                 i_wb_we,
	input logic [`ARM_XLEN-1:0] i_wb_adr,
	input logic                 i_wb_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0; // assertion failures so far

	stb_inside_cyc: assert property (@(posedge clk) disable iff (!rstn)
		i_wb_stb |-> i_wb_cyc)
		else begin
			$error("wishbone stb high without cyc");
			fail_count++;
		end

	// request held while the slave stalls
	req_stable: assert property (@(posedge clk) disable iff (!rstn)
		(i_wb_stb && !i_wb_ack) |=> ($stable(i_wb_adr) && $stable(i_wb_we)))
		else begin
			$error("wishbone address or we changed before ack");
			fail_count++;
		end

	// every transfer, fetch or data, ends with an idle bus cycle
	cyc_drop_after_ack: assert property (@(posedge clk) disable iff (!rstn)
		(i_wb_cyc && i_wb_ack) |=> !i_wb_cyc)
		else begin
			$error("wishbone cyc still high in the cycle after an ack");
			fail_count++;
		end
endmodule

bind arm_core_ctrl armv4t_lite_assert u_wb_assert (
	.clk(clk),
	.rstn(rstn),
	.i_wb_cyc(o_wb_cyc),
	.i_wb_stb(o_wb_stb),
	.i_wb_we(o_wb_we),
	.i_wb_adr(o_wb_adr),
	.i_wb_ack(i_wb_ack)
);

// File: verif/tb_armv4t_lite.sv
`include "armv4t_cfg.svh"

module tb_armv4t_lite;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          MEM_WORDS        = 1024;
	localparam int          CYCLES_PER_STORE = 200;
	localparam int unsigned SEED             = 32'h4fb8_6975;
	localparam string       CASE_FILE        = "verif/armv4t_lite_cases.txt";

	logic                 clk;
	logic                 rstn;
	logic [`ARM_XLEN-1:0] wb_adr;
	logic [`ARM_XLEN-1:0] wb_dat_o;
	logic [`ARM_XLEN-1:0] wb_dat_i;
	logic                 wb_we;
	logic [3:0]           wb_sel;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_ack;

	logic [`ARM_XLEN-1:0] mem [0:MEM_WORDS-1];
	string                exp_name [$];
	logic [`ARM_XLEN-1:0] exp_adr [$];
	logic [`ARM_XLEN-1:0] exp_dat [$];
	logic [3:0]           exp_sel [$];

	int          n_tests;
	int          n_pass;
	int          n_err;
	int          store_idx;
	int unsigned wait_left;
	bit          in_xfer;
	bit          all_stored;
	bit          cases_loaded;

	armv4t_lite i_dut (
		.clk(clk), .rstn(rstn),
		.o_wb_adr(wb_adr), .o_wb_dat(wb_dat_o), .i_wb_dat(wb_dat_i),
		.o_wb_we(wb_we), .o_wb_sel(wb_sel), .o_wb_cyc(wb_cyc),
		.o_wb_stb(wb_stb), .i_wb_ack(wb_ack)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [`ARM_XLEN-1:0] fill_word(logic [`ARM_XLEN-1:0] a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
	endfunction

	task automatic check_addr(input string sig, input logic [`ARM_XLEN-1:0] got,
		input logic [`ARM_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", sig, got, exp);
			n_err++;
		end
	endtask

	task automatic check_data(input string sig, input logic [`ARM_XLEN-1:0] got,
		input logic [`ARM_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", sig, got, exp);
			n_err++;
		end
	endtask

	task automatic check_sel(input string sig, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
			n_err++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (n_err == errs_before) begin
			n_pass++;
			$display("test %-16s ok", name);
		end else begin
			$display("test %-16s mismatch", name);
		end
	endtask

	task automatic load_cases(output bit ok);
		int                   fd;
		int                   n;
		string                line;
		string                tag;
		string                name;
		logic [`ARM_XLEN-1:0] adr;
		logic [`ARM_XLEN-1:0] dat;
		logic [3:0]           sel;
		ok = 1'b0;
		fd = $fopen(CASE_FILE, "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line.getc(0) == "#")
					continue;
				if ($sscanf(line, "%s", tag) != 1)
					continue; // blank line
				if (tag == "M") begin
					n = $sscanf(line, "%s %h %h", tag, adr, dat);
					if (n == 3)
						mem[adr[11:2]] = dat;
				end else if (tag == "E") begin
					n = $sscanf(line, "%s %s %h %h %h", tag, name, adr, dat, sel);
					if (n == 5) begin
						exp_name.push_back(name);
						exp_adr.push_back(adr);
						exp_dat.push_back(dat);
						exp_sel.push_back(sel);
					end
				end else begin
					$display("unknown line in the case file: %s", line);
					n_err++;
				end
			end
			$fclose(fd);
		end
	endtask

	// store seen on the bus, merged into memory and compared in order
	task automatic record_store();
		int errs_before;
		errs_before = n_err;
		for (int b = 0; b < 4; b++) begin
			if (wb_sel[b])
				mem[wb_adr[11:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
		end
		if (store_idx >= exp_adr.size()) begin
			$display("unexpected store to 0x%08h after the last expected one", wb_adr);
			n_err++;
		end else begin
			check_addr("o_wb_adr", wb_adr, exp_adr[store_idx]);
			check_data("o_wb_dat", wb_dat_o, exp_dat[store_idx]);
			check_sel("o_wb_sel", wb_sel, exp_sel[store_idx]);
			report_test(exp_name[store_idx], errs_before);
			store_idx++;
			if (store_idx == exp_adr.size())
				all_stored = 1'b1;
		end
	endtask

	// wishbone slave with 0..3 random wait states
	always @(negedge clk) begin
		if (!rstn) begin
			wb_ack  = 1'b0;
			in_xfer = 1'b0;
		end else if (wb_ack) begin
			wb_ack  = 1'b0; // transfer closed at the last rising edge
			in_xfer = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!in_xfer) begin
				in_xfer   = 1'b1;
				wait_left = $urandom_range(3, 0);
			end
			if (wait_left == 0) begin
				if (wb_we)
					record_store();
				else
					wb_dat_i = mem[wb_adr[11:2]];
				wb_ack = 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	initial begin
		wait (cases_loaded);
		repeat (CYCLES_PER_STORE * exp_adr.size()) @(posedge clk);
		$display("timeout: the core did not finish its stores within %0d cycles",
			CYCLES_PER_STORE * exp_adr.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		bit ok;
		int errs_before;
		rstn     = 1'b0;
		wb_ack   = 1'b0;
		wb_dat_i = '0;
		void'($urandom(SEED));
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(i * 4);
		load_cases(ok);
		if (ok) begin
			cases_loaded = 1'b1;
			repeat (3) @(posedge clk);
			@(negedge clk);
			rstn = 1'b1;
			do
				@(negedge clk);
			while (!wb_cyc);
			errs_before = n_err;
			check_addr("o_wb_adr", wb_adr, `ARM_RESET_PC);
			if (wb_we !== 1'b0) begin
				$display("first bus cycle after reset is not a read");
				n_err++;
			end
			report_test("reset_fetch", errs_before);
			wait (all_stored);
		end else begin
			$display("could not open the case file %s", CASE_FILE);
			n_err++;
		end
		$display("tests run %0d, passed %0d, check errors %0d, assertion failures %0d",
			n_tests, n_pass, n_err, i_dut.u_ctrl.u_wb_assert.fail_count);
		if (n_err == 0 && i_dut.u_ctrl.u_wb_assert.fail_count == 0
			&& store_idx == exp_adr.size() && n_tests > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end
endmodule

// File: armv4t_lite.f
+incdir+include
source/armv4t_pkg.sv
source/arm_exec_if.sv
source/arm_regfile.sv
source/arm_barrel_shifter.sv
source/arm_alu.sv
source/arm_core_ctrl.sv
source/armv4t_lite.sv
verif/armv4t_lite_assert.sv
verif/tb_armv4t_lite.sv

// File: Bender.yml
package:
  name: armv4t_lite

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/armv4t_pkg.sv
      - source/arm_exec_if.sv
      - source/arm_regfile.sv
      - source/arm_barrel_shifter.sv
      - source/arm_alu.sv
      - source/arm_core_ctrl.sv
      - source/armv4t_lite.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/armv4t_lite_assert.sv
      - verif/tb_armv4t_lite.sv

// File: verif/armv4t_lite_cases.txt
# M <byte address> <word>                           program and data image
# E <test name> <store address> <store data> <byte select>   expected stores in order
M 00000000 e3a0ac02   mov r10, #0x200
M 00000004 e3a000ff   mov r0, #0xff
M 00000008 e3a012ff   mov r1, #0xf000000f
M 0000000c e0802201   add r2, r0, r1, lsl #4
M 00000010 e58a2000   str r2, [r10]
M 00000014 e1b03061   movs r3, r1, rrx
M 00000018 e58a3004   str r3, [r10, #4]
M 0000001c e1a04060   mov r4, r0, rrx
M 00000020 e58a4008   str r4, [r10, #8]
M 00000024 e3a05003   mov r5, #3
M 00000028 e1a06551   mov r6, r1, asr r5
M 0000002c e1867570   orr r7, r6, r0, ror r5
M 00000030 e58a700c   str r7, [r10, #12]
M 00000034 e3550003   cmp r5, #3
M 00000038 03a08011   moveq r8, #0x11
M 0000003c 13a08022   movne r8, #0x22
M 00000040 e58a8010   str r8, [r10, #16]
M 00000044 e0919001   adds r9, r1, r1
M 00000048 43a08033   movmi r8, #0x33
M 0000004c 33a08044   movcc r8, #0x44
M 00000050 e58a8014   str r8, [r10, #20]
M 00000054 e255b004   subs r11, r5, #4
M 00000058 b3a08055   movlt r8, #0x55
M 0000005c 83a08066   movhi r8, #0x66
M 00000060 e58a8018   str r8, [r10, #24]
M 00000064 e58ab01c   str r11, [r10, #28]
M 00000068 e3a0cc03   mov r12, #0x300
M 0000006c e59c0000   ldr r0, [r12]
M 00000070 e5dc1002   ldrb r1, [r12, #2]
M 00000074 e50a0004   str r0, [r10, #-4]
M 00000078 e5ca1031   strb r1, [r10, #0x31]
M 0000007c e55c2001   ldrb r2, [r12, #-1]
M 00000080 e54a2002   strb r2, [r10, #-2]
M 00000084 e51c3004   ldr r3, [r12, #-4]
M 00000088 e58a3020   str r3, [r10, #32]
M 0000008c ea000001   b 0x98
M 00000090 e3a08077   mov r8, #0x77
M 00000094 e58a8024   str r8, [r10, #36]
M 00000098 e3a08088   mov r8, #0x88
M 0000009c e58a8024   str r8, [r10, #36]
M 000000a0 eb000001   bl 0xac
M 000000a4 e58ae028   str r14, [r10, #40]
M 000000a8 eafffffe   b 0xa8
M 000000ac e3a08099   mov r8, #0x99
M 000000b0 e58a802c   str r8, [r10, #44]
M 000000b4 e1a0f00e   mov pc, lr
M 000002fc a1b2c3d4   load data
M 00000300 11223344   load data
E dp_lsl        00000200 000001ef f
E dp_rrx_c0     00000204 78000007 f
E dp_rrx_c1     00000208 8000007f f
E dp_shift_reg  0000020c fe00001f f
E cond_eq       00000210 00000011 f
E cond_mi_cc    00000214 00000033 f
E cond_lt_hi    00000218 00000055 f
E subs_result   0000021c ffffffff f
E str_neg       000001fc 11223344 f
E strb_pos      00000231 22222222 2
E strb_neg      000001fe a1a1a1a1 4
E ldr_neg       00000220 a1b2c3d4 f
E branch_skip   00000224 00000088 f
E bl_sub        0000022c 00000099 f
E bl_link       00000228 000000a4 f
